// File: src/rv_isa_pkg.sv
// base RV32I encoding constants shared by the decoder and the testbench
// only the major opcodes that the compressed forms expand into are listed
// register numbers are architectural, x0 to x2

package rv_isa_pkg;

  // one full-width instruction word
  typedef logic [31:0] instr_t;

  //////////////////////////////////////////////////
  // major opcodes, bits [6:0]
  //////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPCODE_OPIMM  = 7'b001_0011;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPCODE_STORE  = 7'b010_0011;
  localparam logic [6:0] OPCODE_OP     = 7'b011_0011;
  localparam logic [6:0] OPCODE_LUI    = 7'b011_0111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPCODE_JALR   = 7'b110_0111;
  localparam logic [6:0] OPCODE_JAL    = 7'b110_1111;

  //////////////////////////////////////////////////
  // register numbers
  //////////////////////////////////////////////////

  // hardwired zero
  localparam logic [4:0] REG_ZERO = 5'd0;
  // link register for jal and jalr
  localparam logic [4:0] REG_RA   = 5'd1;
  // stack pointer, base of the sp-relative forms
  localparam logic [4:0] REG_SP   = 5'd2;

  //////////////////////////////////////////////////
  // fixed words
  //////////////////////////////////////////////////

  // system opcode with funct12 = 1
  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

endpackage

// File: src/cdec_pkg.sv
// decoder-side types for the RV32C expander
// the quadrant is the low two bits of the fetched word, 11 marks a 32-bit word

package cdec_pkg;

  // one compressed half-word
  typedef logic [15:0] cinstr_t;

  // instruction quadrant, taken from bits [1:0]
  typedef enum logic [1:0] {
    QUAD_C0   = 2'b00,
    QUAD_C1   = 2'b01,
    QUAD_C2   = 2'b10,
    QUAD_RV32 = 2'b11
  } quad_e;

  // 3-bit rd'/rs1'/rs2' fields only reach x8..x15,
  // so the full number is this prefix plus the short field
  localparam logic [1:0] CPRIME_BASE = 2'b01;

endpackage

// File: src/cdec_quad0.sv
// quadrant C0 expander, purely combinational
// only c.addi4spn, c.lw and c.sw are legal, float and reserved forms are flagged
// the result is only meaningful when bits [1:0] are 00, the stage selects it
// an illegal result always sets both read enables

`timescale 1ns/10ps

module cdec_quad0 import rv_isa_pkg::*, cdec_pkg::*; (
  input  cinstr_t cinstr_i,
  output instr_t  exp_o,
  output logic    illegal_o,
  output logic    rs1_en_o,
  output logic    rs2_en_o
);

  cinstr_t    ci;
  // rd' / rs2' from [4:2]
  logic [4:0] rd_p;
  // rs1' from [9:7]
  logic [4:0] rs1_p;

  assign ci    = cinstr_i;
  assign rd_p  = {CPRIME_BASE, ci[4:2]};
  assign rs1_p = {CPRIME_BASE, ci[9:7]};

  always_comb begin
    // c.lw shape is the fallback for every arm
    exp_o     = {5'b0, ci[5], ci[12:10], ci[6], 2'b00, rs1_p, 3'b010, rd_p, OPCODE_LOAD};
    illegal_o = 1'b0;
    rs1_en_o  = 1'b1;
    rs2_en_o  = 1'b0;

    case (ci[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', x2, nzuimm
        exp_o = {2'b0, ci[10:7], ci[12:11], ci[5], ci[6], 2'b00, REG_SP, 3'b000, rd_p,
                 OPCODE_OPIMM};
        // zero immediate is reserved, all-zero word included
        illegal_o = (ci[12:5] == 8'b0);
      end
      3'b010: begin
        // c.lw -> lw rd', uimm(rs1'), fallback already in place
        illegal_o = 1'b0;
      end
      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1')
        exp_o    = {5'b0, ci[5], ci[12], rd_p, rs1_p, 3'b010, ci[11:10], ci[6], 2'b00,
                    OPCODE_STORE};
        rs2_en_o = 1'b1;
      end
      // c.fld, c.flw, c.fsd, c.fsw and the reserved 100
      default: illegal_o = 1'b1;
    endcase

    if (illegal_o) begin
      rs1_en_o = 1'b1;
      rs2_en_o = 1'b1;
    end
  end

  // a legal c.addi4spn never expands to a zero immediate
  always_comb begin
    if (!illegal_o && cinstr_i[15:13] == 3'b000) begin
      assert (exp_o[31:20] != 12'b0)
        else $error("C0 expander let a zero-immediate c.addi4spn through");
    end
  end

endmodule

// File: src/cdec_quad1.sv
// quadrant C1 expander, purely combinational
// hint encodings (rd = x0, zero shamt, c.nop) expand like the normal form
// reserved: zero-immediate c.lui/c.addi16sp, shamt[5] set, c.subw/c.addw row
// the result is only meaningful when bits [1:0] are 01, the stage selects it

`timescale 1ns/10ps

module cdec_quad1 import rv_isa_pkg::*, cdec_pkg::*; (
  input  cinstr_t cinstr_i,
  output instr_t  exp_o,
  output logic    illegal_o,
  output logic    rs1_en_o,
  output logic    rs2_en_o
);

  cinstr_t     ci;
  // full rd/rs1 from [11:7]
  logic [4:0]  rd;
  // rd'/rs1' from [9:7] and rs2' from [4:2]
  logic [4:0]  rd_p;
  logic [4:0]  rs2_p;
  // sign-extended 6-bit immediate {[12], [6:2]}
  logic [11:0] imm6;
  // funct3 of the register-register row
  logic [2:0]  alu_f3;

  assign ci    = cinstr_i;
  assign rd    = ci[11:7];
  assign rd_p  = {CPRIME_BASE, ci[9:7]};
  assign rs2_p = {CPRIME_BASE, ci[4:2]};
  assign imm6  = {{6{ci[12]}}, ci[12], ci[6:2]};

  // [6:5] picks sub, xor, or, and
  always_comb begin
    case (ci[6:5])
      2'b00:   alu_f3 = 3'b000;
      2'b01:   alu_f3 = 3'b100;
      2'b10:   alu_f3 = 3'b110;
      default: alu_f3 = 3'b111;
    endcase
  end

  always_comb begin
    // c.addi / c.nop -> addi rd, rd, imm
    exp_o     = {imm6, rd, 3'b000, rd, OPCODE_OPIMM};
    illegal_o = 1'b0;
    rs1_en_o  = 1'b1;
    rs2_en_o  = 1'b0;

    case (ci[15:13])
      3'b001, 3'b101: begin
        // c.jal links to ra, c.j links to x0
        exp_o = {ci[12], ci[8], ci[10:9], ci[6], ci[7], ci[2], ci[11], ci[5:3],
                 {9{ci[12]}}, (ci[15] ? REG_ZERO : REG_RA), OPCODE_JAL};
        rs1_en_o = 1'b0;
      end
      3'b010: begin
        // c.li -> addi rd, x0, imm
        exp_o = {imm6, REG_ZERO, 3'b000, rd, OPCODE_OPIMM};
      end
      3'b011: begin
        if (rd == REG_SP) begin
          // c.addi16sp -> addi x2, x2, nzimm*16
          exp_o = {{3{ci[12]}}, ci[4:3], ci[5], ci[2], ci[6], 4'b0, REG_SP, 3'b000, REG_SP,
                   OPCODE_OPIMM};
        end else begin
          // c.lui -> lui rd, nzimm, no source register
          exp_o    = {{15{ci[12]}}, ci[6:2], rd, OPCODE_LUI};
          rs1_en_o = 1'b0;
        end
        illegal_o = ({ci[12], ci[6:2]} == 6'b0);
      end
      3'b100: begin
        case (ci[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, [10] becomes the arithmetic bit 30
            exp_o     = {1'b0, ci[10], 5'b0, ci[6:2], rd_p, 3'b101, rd_p, OPCODE_OPIMM};
            illegal_o = ci[12];
          end
          2'b10: begin
            // c.andi -> andi rd', rd', imm
            exp_o = {imm6, rd_p, 3'b111, rd_p, OPCODE_OPIMM};
          end
          default: begin
            // sub sets bit 30, [12] set is the RV64 subw/addw row
            exp_o     = {1'b0, ~|ci[6:5], 5'b0, rs2_p, rd_p, alu_f3, rd_p, OPCODE_OP};
            rs2_en_o  = 1'b1;
            illegal_o = ci[12];
          end
        endcase
      end
      3'b110, 3'b111: begin
        // c.beqz / c.bnez -> beq/bne rs1', x0, off, funct3 lsb is [13]
        exp_o = {{4{ci[12]}}, ci[6:5], ci[2], REG_ZERO, rd_p, 2'b00, ci[13],
                 ci[11:10], ci[4:3], ci[12], OPCODE_BRANCH};
        rs2_en_o = 1'b1;
      end
      default: illegal_o = 1'b0;
    endcase

    if (illegal_o) begin
      rs1_en_o = 1'b1;
      rs2_en_o = 1'b1;
    end
  end

endmodule

// File: src/cdec_quad2.sv
// quadrant C2 expander, purely combinational
// c.mv reads x0 as rs1, so it enables both ports like any register add
// reserved: shamt[5] set, c.lwsp to x0, c.jr from x0 and all float sp forms
// the result is only meaningful when bits [1:0] are 10, the stage selects it

`timescale 1ns/10ps

module cdec_quad2 import rv_isa_pkg::*, cdec_pkg::*; (
  input  cinstr_t cinstr_i,
  output instr_t  exp_o,
  output logic    illegal_o,
  output logic    rs1_en_o,
  output logic    rs2_en_o
);

  cinstr_t    ci;
  // full rd/rs1 from [11:7], full rs2 from [6:2]
  logic [4:0] rd;
  logic [4:0] rs2;

  assign ci  = cinstr_i;
  assign rd  = ci[11:7];
  assign rs2 = ci[6:2];

  always_comb begin
    // c.lwsp shape, also used by the float forms
    exp_o     = {4'b0, ci[3:2], ci[12], ci[6:4], 2'b00, REG_SP, 3'b010, rd, OPCODE_LOAD};
    illegal_o = 1'b0;
    rs1_en_o  = 1'b1;
    rs2_en_o  = 1'b0;

    case (ci[15:13])
      3'b000: begin
        // c.slli -> slli rd, rd, shamt
        exp_o     = {7'b0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
        illegal_o = ci[12];
      end
      3'b010: begin
        // c.lwsp -> lw rd, uimm(x2)
        illegal_o = (rd == REG_ZERO);
      end
      3'b100: begin
        if (rs2 == REG_ZERO) begin
          if (!ci[12]) begin
            // c.jr -> jalr x0, 0(rs1)
            exp_o     = {12'b0, rd, 3'b000, REG_ZERO, OPCODE_JALR};
            illegal_o = (rd == REG_ZERO);
          end else if (rd == REG_ZERO) begin
            // c.ebreak, no register read
            exp_o    = INSTR_EBREAK;
            rs1_en_o = 1'b0;
          end else begin
            // c.jalr -> jalr ra, 0(rs1)
            exp_o = {12'b0, rd, 3'b000, REG_RA, OPCODE_JALR};
          end
        end else begin
          // [12] clear: c.mv -> add rd, x0, rs2
          // [12] set:   c.add -> add rd, rd, rs2
          exp_o    = {7'b0, rs2, (ci[12] ? rd : REG_ZERO), 3'b000, rd, OPCODE_OP};
          rs2_en_o = 1'b1;
        end
      end
      3'b110: begin
        // c.swsp -> sw rs2, uimm(x2)
        exp_o    = {4'b0, ci[8:7], ci[12], rs2, REG_SP, 3'b010, ci[11:9], 2'b00,
                    OPCODE_STORE};
        rs2_en_o = 1'b1;
      end
      // c.fldsp, c.flwsp, c.fsdsp, c.fswsp
      default: illegal_o = 1'b1;
    endcase

    if (illegal_o) begin
      rs1_en_o = 1'b1;
      rs2_en_o = 1'b1;
    end
  end

endmodule

// File: src/cdec_stage.sv
// quadrant select and single output register of the decoder
// one word per cycle, no stall: outputs describe the word taken one edge earlier
// data outputs only load on valid_i, so they hold across bubbles
// 32-bit words pass unchanged and are never flagged illegal here

`timescale 1ns/10ps

module cdec_stage import rv_isa_pkg::*, cdec_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   valid_i,
  input  instr_t instr_i,
  input  instr_t q0_exp_i,
  input  logic   q0_illegal_i,
  input  logic   q0_rs1_en_i,
  input  logic   q0_rs2_en_i,
  input  instr_t q1_exp_i,
  input  logic   q1_illegal_i,
  input  logic   q1_rs1_en_i,
  input  logic   q1_rs2_en_i,
  input  instr_t q2_exp_i,
  input  logic   q2_illegal_i,
  input  logic   q2_rs1_en_i,
  input  logic   q2_rs2_en_i,
  output logic   valid_o,
  output instr_t instr_o,
  output logic   is_compressed_o,
  output logic   illegal_instr_o,
  output logic   rs1_enable_o,
  output logic   rs2_enable_o
);

  quad_e  quad;
  instr_t sel_exp;
  logic   sel_illegal;
  logic   sel_rs1_en;
  logic   sel_rs2_en;
  // 32-bit forms that read no register at all
  logic   no_src;

  assign quad   = quad_e'(instr_i[1:0]);
  assign no_src = (instr_i[6:0] == OPCODE_LUI) || (instr_i[6:0] == OPCODE_AUIPC) ||
                  (instr_i[6:0] == OPCODE_JAL);

  //////////////////////////////////////////////////
  // quadrant select
  //////////////////////////////////////////////////

  always_comb begin
    sel_exp     = instr_i;
    sel_illegal = 1'b0;
    sel_rs1_en  = ~no_src;
    sel_rs2_en  = ~no_src;
    case (quad)
      QUAD_C0: begin
        sel_exp     = q0_exp_i;
        sel_illegal = q0_illegal_i;
        sel_rs1_en  = q0_rs1_en_i;
        sel_rs2_en  = q0_rs2_en_i;
      end
      QUAD_C1: begin
        sel_exp     = q1_exp_i;
        sel_illegal = q1_illegal_i;
        sel_rs1_en  = q1_rs1_en_i;
        sel_rs2_en  = q1_rs2_en_i;
      end
      QUAD_C2: begin
        sel_exp     = q2_exp_i;
        sel_illegal = q2_illegal_i;
        sel_rs1_en  = q2_rs1_en_i;
        sel_rs2_en  = q2_rs2_en_i;
      end
      // pass-through, defaults above
      default: sel_exp = instr_i;
    endcase
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o         <= 1'b0;
      instr_o         <= '0;
      is_compressed_o <= 1'b0;
      illegal_instr_o <= 1'b0;
      rs1_enable_o    <= 1'b0;
      rs2_enable_o    <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        instr_o         <= sel_exp;
        is_compressed_o <= (quad != QUAD_RV32);
        illegal_instr_o <= sel_illegal;
        rs1_enable_o    <= sel_rs1_en;
        rs2_enable_o    <= sel_rs2_en;
      end
    end
  end

  // an illegal word always reports both register ports as read
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   valid_o && illegal_instr_o |-> rs1_enable_o && rs2_enable_o)
    else $error("illegal result without both read enables");

  // every legal result is a full-width encoding
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   valid_o && !illegal_instr_o |-> (instr_o[1:0] == 2'b11))
    else $error("legal result is not a 32-bit encoding");

endmodule

// File: src/cdec_top.sv
// RV32C decode stage for a fetch pipeline
// one word accepted per rising edge with valid_i, result one cycle later
// no back-pressure, the consumer has to take every result
// instr_i is always 32 bits, a compressed word sits in [15:0]

`timescale 1ns/10ps

module cdec_top import rv_isa_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   valid_i,
  input  instr_t instr_i,
  output logic   valid_o,
  output instr_t instr_o,
  output logic   is_compressed_o,
  output logic   illegal_instr_o,
  output logic   rs1_enable_o,
  output logic   rs2_enable_o
);

  // per-quadrant results
  instr_t q0_exp;
  logic   q0_illegal;
  logic   q0_rs1_en;
  logic   q0_rs2_en;
  instr_t q1_exp;
  logic   q1_illegal;
  logic   q1_rs1_en;
  logic   q1_rs2_en;
  instr_t q2_exp;
  logic   q2_illegal;
  logic   q2_rs1_en;
  logic   q2_rs2_en;

  //////////////////////////////////////////////////
  // expanders, all see the low half-word
  //////////////////////////////////////////////////

  cdec_quad0 cdec_quad0_i (
    .cinstr_i  (instr_i[15:0]),
    .exp_o     (q0_exp),
    .illegal_o (q0_illegal),
    .rs1_en_o  (q0_rs1_en),
    .rs2_en_o  (q0_rs2_en)
  );

  cdec_quad1 cdec_quad1_i (
    .cinstr_i  (instr_i[15:0]),
    .exp_o     (q1_exp),
    .illegal_o (q1_illegal),
    .rs1_en_o  (q1_rs1_en),
    .rs2_en_o  (q1_rs2_en)
  );

  cdec_quad2 cdec_quad2_i (
    .cinstr_i  (instr_i[15:0]),
    .exp_o     (q2_exp),
    .illegal_o (q2_illegal),
    .rs1_en_o  (q2_rs1_en),
    .rs2_en_o  (q2_rs2_en)
  );

  //////////////////////////////////////////////////
  // select and register
  //////////////////////////////////////////////////

  cdec_stage cdec_stage_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .q0_exp_i        (q0_exp),
    .q0_illegal_i    (q0_illegal),
    .q0_rs1_en_i     (q0_rs1_en),
    .q0_rs2_en_i     (q0_rs2_en),
    .q1_exp_i        (q1_exp),
    .q1_illegal_i    (q1_illegal),
    .q1_rs1_en_i     (q1_rs1_en),
    .q1_rs2_en_i     (q1_rs2_en),
    .q2_exp_i        (q2_exp),
    .q2_illegal_i    (q2_illegal),
    .q2_rs1_en_i     (q2_rs1_en),
    .q2_rs2_en_i     (q2_rs2_en),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o),
    .rs1_enable_o    (rs1_enable_o),
    .rs2_enable_o    (rs2_enable_o)
  );

endmodule

// File: tb/cdec_model.svh
// reference RV32C expansion model and random source for the testbench
// written from the RV32C encoding tables, RV32 base formats only
// the expansion of an illegal word is don't-care, only its flags count
// included inside the testbench module, after the package imports

`ifndef CDEC_MODEL_SVH
`define CDEC_MODEL_SVH

// xorshift32, never reaches zero from a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

//////////////////////////////////////////////////
// base format encoders
//////////////////////////////////////////////////

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] op);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

// branch offset in bytes, bit 0 is dropped
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
endfunction

//////////////////////////////////////////////////
// expansion
//////////////////////////////////////////////////

function automatic void expand_word(input logic [31:0] w, output logic [31:0] exp,
                                    output logic ill, output logic r1, output logic r2,
                                    output logic comp);
  logic [15:0] c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;
  logic [4:0]  rs2p;
  logic [11:0] imm6;
  logic [11:0] uimm;
  logic [19:0] uimm20;
  logic [20:0] joff;
  logic [12:0] boff;
  logic [6:0]  op;
  c    = w[15:0];
  rd   = c[11:7];
  rs2  = c[6:2];
  rdp  = {2'b01, c[9:7]};
  rs2p = {2'b01, c[4:2]};
  imm6 = {{6{c[12]}}, c[12], c[6:2]};
  exp  = 32'h0;
  ill  = 1'b0;
  r1   = 1'b1;
  r2   = 1'b0;
  comp = (w[1:0] != 2'b11);
  case (w[1:0])
    2'b00: begin
      case (c[15:13])
        3'b000: begin
          // c.addi4spn, nzuimm[9:2]
          uimm = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
          exp  = enc_i(uimm, REG_SP, 3'b000, rs2p, OPCODE_OPIMM);
          ill  = (uimm == 12'd0);
        end
        3'b010: begin
          uimm = {5'b0, c[5], c[12:10], c[6], 2'b00};
          exp  = enc_i(uimm, rdp, 3'b010, rs2p, OPCODE_LOAD);
        end
        3'b110: begin
          uimm = {5'b0, c[5], c[12:10], c[6], 2'b00};
          exp  = enc_s(uimm, rs2p, rdp, 3'b010, OPCODE_STORE);
          r2   = 1'b1;
        end
        default: ill = 1'b1;
      endcase
    end
    2'b01: begin
      case (c[15:13])
        3'b000: exp = enc_i(imm6, rd, 3'b000, rd, OPCODE_OPIMM);
        3'b001, 3'b101: begin
          joff = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
          exp  = enc_j(joff, c[15] ? REG_ZERO : REG_RA);
          r1   = 1'b0;
        end
        3'b010: exp = enc_i(imm6, REG_ZERO, 3'b000, rd, OPCODE_OPIMM);
        3'b011: begin
          if (rd == REG_SP) begin
            // c.addi16sp, nzimm[9:4]
            uimm = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0};
            exp  = enc_i(uimm, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM);
          end else begin
            uimm20 = {{14{c[12]}}, c[12], c[6:2]};
            exp    = {uimm20, rd, OPCODE_LUI};
            r1     = 1'b0;
          end
          ill = ({c[12], c[6:2]} == 6'd0);
        end
        3'b100: begin
          case (c[11:10])
            2'b00: begin
              exp = enc_i({7'b0, c[6:2]}, rdp, 3'b101, rdp, OPCODE_OPIMM);
              ill = c[12];
            end
            2'b01: begin
              exp = enc_i({7'b0100000, c[6:2]}, rdp, 3'b101, rdp, OPCODE_OPIMM);
              ill = c[12];
            end
            2'b10: exp = enc_i(imm6, rdp, 3'b111, rdp, OPCODE_OPIMM);
            default: begin
              case (c[6:5])
                2'b00:   exp = enc_r(7'b0100000, rs2p, rdp, 3'b000, rdp, OPCODE_OP);
                2'b01:   exp = enc_r(7'b0000000, rs2p, rdp, 3'b100, rdp, OPCODE_OP);
                2'b10:   exp = enc_r(7'b0000000, rs2p, rdp, 3'b110, rdp, OPCODE_OP);
                default: exp = enc_r(7'b0000000, rs2p, rdp, 3'b111, rdp, OPCODE_OP);
              endcase
              r2  = 1'b1;
              ill = c[12];
            end
          endcase
        end
        default: begin
          // c.beqz and c.bnez
          boff = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
          exp  = enc_b(boff, REG_ZERO, rdp, {2'b00, c[13]});
          r2   = 1'b1;
        end
      endcase
    end
    2'b10: begin
      case (c[15:13])
        3'b000: begin
          exp = enc_i({7'b0, c[6:2]}, rd, 3'b001, rd, OPCODE_OPIMM);
          ill = c[12];
        end
        3'b010: begin
          uimm = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
          exp  = enc_i(uimm, REG_SP, 3'b010, rd, OPCODE_LOAD);
          ill  = (rd == REG_ZERO);
        end
        3'b100: begin
          if (!c[12] && rs2 == REG_ZERO) begin
            exp = enc_i(12'd0, rd, 3'b000, REG_ZERO, OPCODE_JALR);
            ill = (rd == REG_ZERO);
          end else if (!c[12]) begin
            exp = enc_r(7'b0, rs2, REG_ZERO, 3'b000, rd, OPCODE_OP);
            r2  = 1'b1;
          end else if (rs2 == REG_ZERO && rd == REG_ZERO) begin
            exp = INSTR_EBREAK;
            r1  = 1'b0;
          end else if (rs2 == REG_ZERO) begin
            exp = enc_i(12'd0, rd, 3'b000, REG_RA, OPCODE_JALR);
          end else begin
            exp = enc_r(7'b0, rs2, rd, 3'b000, rd, OPCODE_OP);
            r2  = 1'b1;
          end
        end
        3'b110: begin
          uimm = {4'b0, c[8:7], c[12:9], 2'b00};
          exp  = enc_s(uimm, rs2, REG_SP, 3'b010, OPCODE_STORE);
          r2   = 1'b1;
        end
        default: ill = 1'b1;
      endcase
    end
    default: begin
      // full-width word goes through untouched
      exp = w;
      op  = w[6:0];
      r1  = !(op == OPCODE_LUI || op == OPCODE_AUIPC || op == OPCODE_JAL);
      r2  = r1;
    end
  endcase
  if (ill) begin
    r1 = 1'b1;
    r2 = 1'b1;
  end
endfunction

`endif

// File: tb/tb_cdec.sv
// random and directed test of the RV32C decode stage
// inputs change on the falling edge, outputs are sampled on the next falling edge
// expected results come from the model in cdec_model.svh

`timescale 1ns/10ps

module tb_cdec import rv_isa_pkg::*, cdec_pkg::*; ();

  `include "cdec_model.svh"

  localparam int RESET_CYCLES = 16;
  localparam int N_TIMING     = 64;
  localparam int N_C0         = 200;
  localparam int N_C1         = 300;
  localparam int N_C2         = 300;
  localparam int N_RV32       = 200;
  localparam int N_ILLEGAL    = 16;
  // every test word takes one cycle, twice that leaves room for drains
  localparam int CYCLE_LIMIT  =
    2 * (N_TIMING + N_C0 + N_C1 + N_C2 + N_RV32 + N_ILLEGAL) + RESET_CYCLES;

  logic   clk_i;
  logic   rst_n_i;
  logic   valid_i;
  instr_t instr_i;
  logic   valid_o;
  instr_t instr_o;
  logic   is_compressed_o;
  logic   illegal_instr_o;
  logic   rs1_enable_o;
  logic   rs2_enable_o;

  // scoreboard, one entry per accepted word
  logic [31:0] word_q[$];
  logic [31:0] exp_q[$];
  // {is_compressed, illegal, rs1_en, rs2_en}
  logic [3:0]  flag_q[$];

  // last expected result, the data outputs keep it across bubbles
  logic [31:0] held_exp;
  logic [3:0]  held_flags;
  // expansion of an illegal word is not defined
  logic        held_exp_known;

  logic [31:0] rng;
  logic        prev_valid;
  int          cycles;
  int          test_errors;
  int          total_errors;
  int          tests_passed;
  int          tests_failed;
  string       test_name;

  const logic [15:0] illegal_words [N_ILLEGAL] = '{
    16'h0000, 16'h4002, 16'h8002, 16'h2000, 16'h6000, 16'hA000, 16'hE000, 16'h8000,
    16'h9C01, 16'h9C21, 16'h1086, 16'h9085, 16'h9485, 16'h6181, 16'h6101, 16'h2002
  };

  cdec_top cdec_top_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o),
    .rs1_enable_o    (rs1_enable_o),
    .rs2_enable_o    (rs2_enable_o)
  );

  always #5 clk_i = ~clk_i;

  // hard stop for a stuck run
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the decoder stopped producing results", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  //////////////////////////////////////////////////
  // scoreboard and driver
  //////////////////////////////////////////////////

  task automatic check_outputs();
    logic [31:0] w;
    logic [31:0] e;
    logic [3:0]  f;
    assert (valid_o == prev_valid)
      else begin
        $display("Fail %s valid_o expected %0b actual %0b", test_name, prev_valid, valid_o);
        test_errors++;
      end
    // bubble, data outputs keep the last result
    if (!prev_valid) begin
      if (held_exp_known) begin
        assert (instr_o == held_exp)
          else begin
            $display("Fail %s held instr_o expected %h actual %h", test_name, held_exp,
                     instr_o);
            test_errors++;
          end
      end
      assert ({is_compressed_o, illegal_instr_o, rs1_enable_o, rs2_enable_o} == held_flags)
        else begin
          $display("Fail %s held flags expected %b actual %b", test_name, held_flags,
                   {is_compressed_o, illegal_instr_o, rs1_enable_o, rs2_enable_o});
          test_errors++;
        end
    end
    if (prev_valid && word_q.size() > 0) begin
      w = word_q.pop_front();
      e = exp_q.pop_front();
      f = flag_q.pop_front();
      // expansion of an illegal word is not defined
      if (!f[2]) begin
        assert (instr_o == e)
          else begin
            $display("Fail %s word %h instr_o expected %h actual %h", test_name, w, e, instr_o);
            test_errors++;
          end
      end
      assert ({is_compressed_o, illegal_instr_o, rs1_enable_o, rs2_enable_o} == f)
        else begin
          $display("Fail %s word %h flags expected %b actual %b", test_name, w, f,
                   {is_compressed_o, illegal_instr_o, rs1_enable_o, rs2_enable_o});
          test_errors++;
        end
      held_exp       = e;
      held_flags     = f;
      held_exp_known = !f[2];
    end
  endtask

  task automatic drive(input logic v, input logic [31:0] w);
    logic [31:0] e;
    logic        ill;
    logic        r1;
    logic        r2;
    logic        comp;
    @(negedge clk_i);
    check_outputs();
    valid_i = v;
    instr_i = w;
    if (v) begin
      expand_word(w, e, ill, r1, r2, comp);
      word_q.push_back(w);
      exp_q.push_back(e);
      flag_q.push_back({comp, ill, r1, r2});
    end
    prev_valid = v;
  endtask

  // bubbles until every accepted word has been checked
  task automatic finish_test();
    drive(1'b0, next_rand());
    while (word_q.size() != 0) begin
      drive(1'b0, next_rand());
    end
    drive(1'b0, next_rand());
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: pass", test_name);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", test_name, test_errors);
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] e;
    logic        ill;
    logic        r1;
    logic        r2;
    logic        comp;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    valid_i        = 1'b0;
    instr_i        = '0;
    rng            = 32'd23;
    prev_valid     = 1'b0;
    held_exp       = '0;
    held_flags     = '0;
    held_exp_known = 1'b1;
    cycles         = 0;
    test_errors    = 0;
    total_errors   = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;

    // reset values, then random valid with gaps
    test_name = "reset_valid";
    @(negedge clk_i);
    assert ({valid_o, instr_o, is_compressed_o, illegal_instr_o, rs1_enable_o,
             rs2_enable_o} == 37'd0)
      else begin
        $display("Fail %s reset outputs expected %h actual %h", test_name, 37'd0,
                 {valid_o, instr_o, is_compressed_o, illegal_instr_o, rs1_enable_o,
                  rs2_enable_o});
        test_errors++;
      end
    for (int i = 0; i < N_TIMING; i++) begin
      r = next_rand();
      drive(r[31], next_rand());
    end
    finish_test();

    test_name = "quad_c0";
    for (int i = 0; i < N_C0; i++) begin
      r = next_rand();
      drive(1'b1, {r[31:2], 2'b00});
    end
    finish_test();

    test_name = "quad_c1";
    for (int i = 0; i < N_C1; i++) begin
      r = next_rand();
      drive(1'b1, {r[31:2], 2'b01});
    end
    finish_test();

    test_name = "quad_c2";
    for (int i = 0; i < N_C2; i++) begin
      r = next_rand();
      drive(1'b1, {r[31:2], 2'b10});
    end
    finish_test();

    // a quarter of the words get a no-source opcode
    test_name = "pass_rv32";
    for (int i = 0; i < N_RV32; i++) begin
      r = next_rand();
      w = {r[31:2], 2'b11};
      if (r[3:2] == 2'b00) begin
        case (r[5:4])
          2'b00:   w[6:0] = OPCODE_LUI;
          2'b01:   w[6:0] = OPCODE_AUIPC;
          default: w[6:0] = OPCODE_JAL;
        endcase
      end
      drive(1'b1, w);
    end
    finish_test();

    test_name = "illegal_list";
    for (int i = 0; i < N_ILLEGAL; i++) begin
      r = next_rand();
      w = {r[31:16], illegal_words[i]};
      expand_word(w, e, ill, r1, r2, comp);
      assert (ill)
        else begin
          $display("directed word %h is not illegal in the model", w);
          test_errors++;
        end
      drive(1'b1, w);
    end
    finish_test();

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+tb
src/rv_isa_pkg.sv
src/cdec_pkg.sv
src/cdec_quad0.sv
src/cdec_quad1.sv
src/cdec_quad2.sv
src/cdec_stage.sv
src/cdec_top.sv
tb/tb_cdec.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_cdec -o tb_cdec
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_cdec)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi
